//--- build.f
+incdir+src
+incdir+tests
src/issue_pkg.sv
src/gpr_regfile.sv
src/issue_hazard_check.sv
src/operand_select.sv
src/dispatch_regs.sv
src/issue_read_operands.sv
tests/tb_issue_read_operands.sv

//--- src/dispatch_regs.sv
// ID/EX pipeline register with one-cycle per-unit valid strobes
`timescale 1ns/1ns
`include "issue_consts.svh"

module dispatch_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_instr_valid_i,
    input  logic                    issue_ack_i,
    input  issue_pkg::xlen_t        operand_a_i,
    input  issue_pkg::xlen_t        operand_b_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    lsu_valid_o,
    output logic                    mult_valid_o,
    output logic                    csr_valid_o,
    output logic                    mult_pending_o
);
    import issue_pkg::*;

    // strobe bit positions
    localparam int unsigned STB_ALU    = 0;
    localparam int unsigned STB_BRANCH = 1;
    localparam int unsigned STB_LSU    = 2;
    localparam int unsigned STB_MULT   = 3;
    localparam int unsigned STB_CSR    = 4;

    logic       issue_fire;
    logic [4:0] strobe_n;
    logic [4:0] strobe_q;

    // accepted and not an exception pass-through
    assign issue_fire = issue_instr_valid_i && issue_ack_i && !issue_instr_i.ex_valid;

    // ------------------------------
    // strobe decode
    // ------------------------------
    always_comb begin
        strobe_n = '0;
        if (issue_fire && !flush_i) begin
            case (issue_instr_i.fu)
                ALU:         strobe_n[STB_ALU]    = 1'b1;
                CTRL_FLOW:   strobe_n[STB_BRANCH] = 1'b1;
                LOAD, STORE: strobe_n[STB_LSU]    = 1'b1;
                MULT:        strobe_n[STB_MULT]   = 1'b1;
                CSR:         strobe_n[STB_CSR]    = 1'b1;
                // NONE raises nothing
                default:     strobe_n             = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            strobe_q <= '0;
        end else begin
            strobe_q <= strobe_n;
        end
    end

    assign alu_valid_o    = strobe_q[STB_ALU];
    assign branch_valid_o = strobe_q[STB_BRANCH];
    assign lsu_valid_o    = strobe_q[STB_LSU];
    assign mult_valid_o   = strobe_q[STB_MULT];
    assign csr_valid_o    = strobe_q[STB_CSR];
    // multiplier owns the result bus next cycle
    assign mult_pending_o = strobe_q[STB_MULT];

    // ------------------------------
    // payload register
    // ------------------------------
    // loads every cycle, the strobes say whether it counts
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
            pc_o      <= '0;
        end else begin
            fu_data_o.fu        <= issue_instr_i.fu;
            fu_data_o.op        <= issue_instr_i.op;
            fu_data_o.operand_a <= operand_a_i;
            fu_data_o.operand_b <= operand_b_i;
            // store data offset and branch target live here
            fu_data_o.imm       <= issue_instr_i.result;
            fu_data_o.trans_id  <= issue_instr_i.trans_id;
            pc_o                <= issue_instr_i.pc;
        end
    end

endmodule

//--- src/gpr_regfile.sv
// integer register file: two combinational reads, parallel commit writes, x0 tied to zero
`timescale 1ns/1ns
`include "issue_consts.svh"

module gpr_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  issue_pkg::reg_addr_t                        raddr_a_i,
    input  issue_pkg::reg_addr_t                        raddr_b_i,
    input  issue_pkg::commit_wr_t [NR_COMMIT_PORTS-1:0] commit_i,
    output issue_pkg::xlen_t                            rdata_a_o,
    output issue_pkg::xlen_t                            rdata_b_o
);
    import issue_pkg::*;

    // x1..x31 only, x0 has no storage
    xlen_t [`ISSUE_NR_REGS-1:1] regs_q;

    // ------------------------------
    // write side
    // ------------------------------
    // ports walk upwards so a later port overrides an earlier one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '0;
        end else begin
            for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
                // writes to x0 are dropped
                if (commit_i[i].we && (commit_i[i].waddr != '0)) begin
                    regs_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // same-cycle commit is not bypassed, old value seen
    always_comb begin
        if (raddr_a_i == '0) begin
            rdata_a_o = '0;
        end else begin
            rdata_a_o = regs_q[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == '0) begin
            rdata_b_o = '0;
        end else begin
            rdata_b_o = regs_q[raddr_b_i];
        end
    end

endmodule

//--- src/issue_consts.svh
// issue stage constants: operand, register and tag widths plus default port count
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------
// operand and pc width
`define ISSUE_XLEN 32
// architectural register index width
`define ISSUE_REG_ADDR_BITS 5
// integer register count, x0 included
`define ISSUE_NR_REGS 32

// ------------------------------
// scoreboard and commit
// ------------------------------
// scoreboard slot tag width
`define ISSUE_TRANS_ID_BITS 3
// default number of commit write ports
`define ISSUE_NR_COMMIT_PORTS 2

`endif

//--- src/issue_hazard_check.sv
// issue hazard check: source forwarding and stall, unit busy, write-after-write and acknowledge
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  issue_pkg::issue_instr_t                     issue_instr_i,
    input  logic                                        issue_instr_valid_i,
    input  logic                                        rs1_valid_i,
    input  logic                                        rs2_valid_i,
    input  issue_pkg::clobber_table_t                   rd_clobber_i,
    input  logic                                        flu_ready_i,
    input  logic                                        lsu_ready_i,
    input  issue_pkg::commit_wr_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                        mult_pending_i,
    output logic                                        fwd_rs1_o,
    output logic                                        fwd_rs2_o,
    output logic                                        issue_ack_o
);
    import issue_pkg::*;

    logic stall;
    logic fu_busy;
    logic rd_free;
    logic rd_commit;
    // csr results may only be forwarded into an sfence
    logic csr_fwd_ok;

    assign csr_fwd_ok = (issue_instr_i.op == SFENCE_VMA);

    // ------------------------------
    // source operands
    // ------------------------------
    always_comb begin
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // zimm means rs1 field is an immediate, nothing to wait for
        if (!issue_instr_i.use_zimm && (rd_clobber_i[issue_instr_i.rs1] != NONE)) begin
            if (rs1_valid_i && ((rd_clobber_i[issue_instr_i.rs1] != CSR) || csr_fwd_ok)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (rd_clobber_i[issue_instr_i.rs2] != NONE) begin
            if (rs2_valid_i && ((rd_clobber_i[issue_instr_i.rs2] != CSR) || csr_fwd_ok)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // ------------------------------
    // unit busy
    // ------------------------------
    always_comb begin
        case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------
    // write-after-write
    // ------------------------------
    assign rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);

    // a commit landing on rd this cycle retires the older writer
    always_comb begin
        rd_commit = 1'b0;
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == issue_instr_i.rd)) begin
                rd_commit = 1'b1;
            end
        end
    end

    // ------------------------------
    // acknowledge
    // ------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_commit)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less ops pass straight through
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // one cycle after a multiply only another multiply may go,
        // the fixed latency result bus would collide otherwise
        if (mult_pending_i && (issue_instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

//--- src/issue_pkg.sv
// issue stage types: operand vectors, unit and operation codes, entry and dispatch structs
`include "issue_consts.svh"

package issue_pkg;

    // ------------------------------
    // plain vectors
    // ------------------------------
    // operand, immediate and pc value
    typedef logic [`ISSUE_XLEN-1:0]          xlen_t;
    // architectural register index
    typedef logic [`ISSUE_REG_ADDR_BITS-1:0] reg_addr_t;
    // scoreboard slot tag
    typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;

    // ------------------------------
    // unit and operation codes
    // ------------------------------
    // target unit, also used in the clobber table
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        BEQ,
        JAL,
        LW,
        SW,
        MUL,
        CSRRW,
        SFENCE_VMA
    } fu_op_t;

    // ------------------------------
    // structs
    // ------------------------------
    // one scoreboard entry as seen by issue
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        trans_id_t trans_id;
        // immediate lives in the result field until execution
        xlen_t     result;
        xlen_t     pc;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        // exception already raised upstream
        logic      ex_valid;
    } issue_instr_t;

    // payload handed to the execute units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one commit write port
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_wr_t;

    // youngest uncommitted writer per register
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_table_t;

endpackage

//--- src/issue_read_operands.sv
// issue stage top: register file, hazard check, operand mux and ID/EX registers
`timescale 1ns/1ns
`include "issue_consts.svh"

module issue_read_operands #(
    parameter int unsigned NR_COMMIT_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        flush_i,
    // scoreboard entry, held until acknowledged
    input  issue_pkg::issue_instr_t                     issue_instr_i,
    input  logic                                        issue_instr_valid_i,
    output logic                                        issue_ack_o,
    // scoreboard forwarding lookup
    output issue_pkg::reg_addr_t                        rs1_o,
    output issue_pkg::reg_addr_t                        rs2_o,
    input  issue_pkg::xlen_t                            rs1_i,
    input  issue_pkg::xlen_t                            rs2_i,
    input  logic                                        rs1_valid_i,
    input  logic                                        rs2_valid_i,
    input  issue_pkg::clobber_table_t                   rd_clobber_i,
    // unit readiness
    input  logic                                        flu_ready_i,
    input  logic                                        lsu_ready_i,
    input  issue_pkg::commit_wr_t [NR_COMMIT_PORTS-1:0] commit_i,
    // to execute
    output issue_pkg::fu_data_t                         fu_data_o,
    output issue_pkg::xlen_t                            pc_o,
    output logic                                        alu_valid_o,
    output logic                                        branch_valid_o,
    output logic                                        lsu_valid_o,
    output logic                                        mult_valid_o,
    output logic                                        csr_valid_o
);
    import issue_pkg::*;

    xlen_t rdata_a;
    xlen_t rdata_b;
    xlen_t operand_a_n;
    xlen_t operand_b_n;
    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  mult_pending;

    // lookup addresses follow the entry directly
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    gpr_regfile #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) gpr_regfile_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .commit_i  (commit_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    issue_hazard_check #(
        .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
    ) issue_hazard_check_i (
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .rs1_valid_i         (rs1_valid_i),
        .rs2_valid_i         (rs2_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .commit_i            (commit_i),
        .mult_pending_i      (mult_pending),
        .fwd_rs1_o           (fwd_rs1),
        .fwd_rs2_o           (fwd_rs2),
        .issue_ack_o         (issue_ack_o)
    );

    operand_select operand_select_i (
        .issue_instr_i (issue_instr_i),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .operand_a_o   (operand_a_n),
        .operand_b_o   (operand_b_n)
    );

    dispatch_regs dispatch_regs_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .issue_ack_i         (issue_ack_o),
        .operand_a_i         (operand_a_n),
        .operand_b_i         (operand_b_n),
        .fu_data_o           (fu_data_o),
        .pc_o                (pc_o),
        .alu_valid_o         (alu_valid_o),
        .branch_valid_o      (branch_valid_o),
        .lsu_valid_o         (lsu_valid_o),
        .mult_valid_o        (mult_valid_o),
        .csr_valid_o         (csr_valid_o),
        .mult_pending_o      (mult_pending)
    );

endmodule

//--- src/operand_select.sv
// next-operand mux: register, forwarded, pc, zimm and immediate sources
`timescale 1ns/1ns
`include "issue_consts.svh"

module operand_select (
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  issue_pkg::xlen_t        rdata_a_i,
    input  issue_pkg::xlen_t        rdata_b_i,
    input  issue_pkg::xlen_t        rs1_i,
    input  issue_pkg::xlen_t        rs2_i,
    input  logic                    fwd_rs1_i,
    input  logic                    fwd_rs2_i,
    output issue_pkg::xlen_t        operand_a_o,
    output issue_pkg::xlen_t        operand_b_o
);
    import issue_pkg::*;

    // stores and branches keep rs2 in operand b, imm goes separately
    logic imm_on_b;

    assign imm_on_b = issue_instr_i.use_imm
                      && (issue_instr_i.fu != STORE)
                      && (issue_instr_i.fu != CTRL_FLOW);

    // ------------------------------
    // operand a
    // ------------------------------
    // later assignments take priority
    always_comb begin
        operand_a_o = rdata_a_i;
        if (fwd_rs1_i) begin
            operand_a_o = rs1_i;
        end
        if (issue_instr_i.use_pc) begin
            operand_a_o = issue_instr_i.pc;
        end
        // zimm sits in the rs1 field, zero extended
        if (issue_instr_i.use_zimm) begin
            operand_a_o = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end
    end

    // ------------------------------
    // operand b
    // ------------------------------
    always_comb begin
        operand_b_o = rdata_b_i;
        if (fwd_rs2_i) begin
            operand_b_o = rs2_i;
        end
        if (imm_on_b) begin
            operand_b_o = issue_instr_i.result;
        end
    end

endmodule

//--- tests/issue_ref_model.svh
// issue stage reference model with a shadow register file and the expected ack, operands and strobes
`ifndef ISSUE_REF_MODEL_SVH
`define ISSUE_REF_MODEL_SVH

// ------------------------------
// model state
// ------------------------------
// x0 is never written and entry 0 stays zero
xlen_t shadow_regs [`ISSUE_NR_REGS];
// a multiply strobe is on the outputs this cycle
logic  mult_pending_exp;

// source condition is 0 when free, 1 when forwarded and 2 when issue stalls
function automatic int src_state(input fu_t clob, input logic vld, input fu_op_t op);
    if (clob == NONE) begin
        return 0;
    end
    // csr producers only feed an sfence
    if (!vld || ((clob == CSR) && (op != SFENCE_VMA))) begin
        return 2;
    end
    return 1;
endfunction

function automatic logic predict_ack(input issue_instr_t ins, input logic valid,
                                     input clobber_table_t clob, input logic v1, input logic v2,
                                     input logic flu, input logic lsu,
                                     input commit_wr_t [1:0] cmt);
    int   s1;
    int   s2;
    logic busy;
    logic rd_hit;
    logic ack;
    s1 = ins.use_zimm ? 0 : src_state(clob[ins.rs1], v1, ins.op);
    s2 = src_state(clob[ins.rs2], v2, ins.op);
    busy = 1'b0;
    if ((ins.fu == ALU) || (ins.fu == CTRL_FLOW) || (ins.fu == MULT) || (ins.fu == CSR)) begin
        busy = !flu;
    end
    if ((ins.fu == LOAD) || (ins.fu == STORE)) begin
        busy = !lsu;
    end
    rd_hit = (cmt[0].we && (cmt[0].waddr == ins.rd)) || (cmt[1].we && (cmt[1].waddr == ins.rd));
    ack = valid && (s1 != 2) && (s2 != 2) && !busy && ((clob[ins.rd] == NONE) || rd_hit);
    if (valid && (ins.ex_valid || (ins.fu == NONE))) begin
        ack = 1'b1;
    end
    if (mult_pending_exp && (ins.fu != MULT)) begin
        ack = 1'b0;
    end
    return ack;
endfunction

function automatic xlen_t operand_a_model(input issue_instr_t ins, input clobber_table_t clob,
                                          input logic vld, input xlen_t fwd);
    xlen_t a;
    a = shadow_regs[ins.rs1];
    if (!ins.use_zimm && (src_state(clob[ins.rs1], vld, ins.op) == 1)) begin
        a = fwd;
    end
    if (ins.use_pc) begin
        a = ins.pc;
    end
    if (ins.use_zimm) begin
        a = xlen_t'(ins.rs1);
    end
    return a;
endfunction

function automatic xlen_t operand_b_model(input issue_instr_t ins, input clobber_table_t clob,
                                          input logic vld, input xlen_t fwd);
    xlen_t b;
    b = shadow_regs[ins.rs2];
    if (src_state(clob[ins.rs2], vld, ins.op) == 1) begin
        b = fwd;
    end
    if (ins.use_imm && (ins.fu != STORE) && (ins.fu != CTRL_FLOW)) begin
        b = ins.result;
    end
    return b;
endfunction

// strobe bits from 0 up are alu, branch, lsu, mult and csr
function automatic logic [4:0] decode_strobes(input issue_instr_t ins, input logic fire,
                                              input logic flush);
    logic [4:0] s;
    s = '0;
    if (fire && !ins.ex_valid && !flush) begin
        case (ins.fu)
            ALU:         s[0] = 1'b1;
            CTRL_FLOW:   s[1] = 1'b1;
            LOAD, STORE: s[2] = 1'b1;
            MULT:        s[3] = 1'b1;
            CSR:         s[4] = 1'b1;
            default:     s    = '0;
        endcase
    end
    return s;
endfunction

// higher port applied last and so it wins a collision
task automatic apply_commits(input commit_wr_t [1:0] cmt);
    for (int p = 0; p < 2; p++) begin
        if (cmt[p].we && (cmt[p].waddr != '0)) begin
            shadow_regs[cmt[p].waddr] = cmt[p].wdata;
        end
    end
endtask

`endif

//--- tests/tb_issue_read_operands.sv
// issue stage testbench that checks random LFSR instructions against a reference model
`timescale 1ns/1ns
`include "issue_consts.svh"

module tb_issue_read_operands;
    import issue_pkg::*;

    localparam int unsigned NR_PORTS  = 2;
    localparam int unsigned NR_INSTRS = 400;
    localparam int unsigned MAX_WAIT  = 50;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      flush_i;
    issue_instr_t              issue_instr_i;
    logic                      issue_instr_valid_i;
    logic                      issue_ack_o;
    reg_addr_t                 rs1_o;
    reg_addr_t                 rs2_o;
    xlen_t                     rs1_i;
    xlen_t                     rs2_i;
    logic                      rs1_valid_i;
    logic                      rs2_valid_i;
    clobber_table_t            rd_clobber_i;
    logic                      flu_ready_i;
    logic                      lsu_ready_i;
    commit_wr_t [NR_PORTS-1:0] commit_i;
    fu_data_t                  fu_data_o;
    xlen_t                     pc_o;
    logic                      alu_valid_o;
    logic                      branch_valid_o;
    logic                      lsu_valid_o;
    logic                      mult_valid_o;
    logic                      csr_valid_o;
    logic [4:0]                strobes;

    logic [15:0] lfsr_q;

    // expectations for what the next edge registers
    logic       have_prev;
    xlen_t      prev_a;
    xlen_t      prev_b;
    xlen_t      prev_imm;
    xlen_t      prev_pc;
    fu_t        prev_fu;
    fu_op_t     prev_op;
    trans_id_t  prev_tid;
    logic [4:0] prev_strobe;

    `include "issue_ref_model.svh"

    assign strobes = {csr_valid_o, mult_valid_o, lsu_valid_o, branch_valid_o, alu_valid_o};

    issue_read_operands #(
        .NR_COMMIT_PORTS (NR_PORTS)
    ) issue_read_operands_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .issue_ack_o         (issue_ack_o),
        .rs1_o               (rs1_o),
        .rs2_o               (rs2_o),
        .rs1_i               (rs1_i),
        .rs2_i               (rs2_i),
        .rs1_valid_i         (rs1_valid_i),
        .rs2_valid_i         (rs2_valid_i),
        .rd_clobber_i        (rd_clobber_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .commit_i            (commit_i),
        .fu_data_o           (fu_data_o),
        .pc_o                (pc_o),
        .alu_valid_o         (alu_valid_o),
        .branch_valid_o      (branch_valid_o),
        .lsu_valid_o         (lsu_valid_o),
        .mult_valid_o        (mult_valid_o),
        .csr_valid_o         (csr_valid_o)
    );

    // 8 ns clock
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic issue_instr_t random_instr();
        issue_instr_t ins;
        ins.fu       = fu_t'(3'(rand_bits(3) % 7));
        ins.op       = fu_op_t'(4'(rand_bits(4) % 13));
        ins.rs1      = reg_addr_t'(rand_bits(5));
        ins.rs2      = reg_addr_t'(rand_bits(5));
        ins.rd       = reg_addr_t'(rand_bits(5));
        ins.trans_id = trans_id_t'(rand_bits(3));
        ins.result   = rand_bits(32);
        ins.pc       = rand_bits(32);
        ins.use_imm  = (rand_bits(1) != 0);
        ins.use_pc   = (rand_bits(2) == 0);
        ins.use_zimm = (rand_bits(2) == 0);
        ins.ex_valid = (rand_bits(4) == 0);
        return ins;
    endfunction

    // calm clears every clobber and readies the units so a held instruction can go
    task automatic drive_cycle(input issue_instr_t ins, input logic valid, input logic calm,
                               input int fill_idx);
        clobber_table_t            clob;
        commit_wr_t [NR_PORTS-1:0] cmt;
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            clob[r] = NONE;
            if (!calm && (rand_bits(2) == 0)) begin
                clob[r] = fu_t'(3'(rand_bits(3) % 7));
            end
        end
        // half the commits aim at rd to hit the write-after-write bypass
        for (int p = 0; p < NR_PORTS; p++) begin
            cmt[p].we    = (rand_bits(2) == 0);
            cmt[p].waddr = rand_bits(1) ? ins.rd : reg_addr_t'(rand_bits(5));
            cmt[p].wdata = rand_bits(32);
        end
        // fill writes two registers per cycle and both ports collide every fourth cycle
        if (fill_idx >= 0) begin
            cmt[0].we    = 1'b1;
            cmt[0].waddr = reg_addr_t'(2 * fill_idx);
            cmt[1].we    = 1'b1;
            cmt[1].waddr = reg_addr_t'(2 * fill_idx + 1);
            if ((fill_idx % 4) == 3) begin
                cmt[1].waddr = cmt[0].waddr;
            end
        end
        @(posedge clk_i);
        issue_instr_i       <= ins;
        issue_instr_valid_i <= valid;
        rd_clobber_i        <= clob;
        commit_i            <= cmt;
        rs1_valid_i         <= (rand_bits(2) != 0);
        rs2_valid_i         <= (rand_bits(2) != 0);
        flu_ready_i         <= calm || (rand_bits(2) != 0);
        lsu_ready_i         <= calm || (rand_bits(2) != 0);
        flush_i             <= (rand_bits(4) == 0);
        // scoreboard lookup answer
        rs1_i               <= rand_bits(32);
        rs2_i               <= rand_bits(32);
    endtask

    // check on the falling edge where inputs and outputs have settled
    task automatic check_cycle(output logic acked);
        logic ack_exp;
        @(negedge clk_i);
        if (have_prev) begin
            check_value(fu_data_o.operand_a, prev_a, "operand a");
            check_value(fu_data_o.operand_b, prev_b, "operand b");
            check_value(fu_data_o.imm, prev_imm, "immediate");
            check_value(fu_data_o.fu, prev_fu, "unit");
            check_value(fu_data_o.op, prev_op, "operation");
            check_value(fu_data_o.trans_id, prev_tid, "transaction id");
            check_value(pc_o, prev_pc, "pc");
            check_value(strobes, prev_strobe, "valid strobes");
        end
        check_value(rs1_o, issue_instr_i.rs1, "rs1 lookup address");
        check_value(rs2_o, issue_instr_i.rs2, "rs2 lookup address");
        ack_exp = predict_ack(issue_instr_i, issue_instr_valid_i, rd_clobber_i, rs1_valid_i,
                              rs2_valid_i, flu_ready_i, lsu_ready_i, commit_i);
        check_value(issue_ack_o, ack_exp, "issue acknowledge");
        prev_a      = operand_a_model(issue_instr_i, rd_clobber_i, rs1_valid_i, rs1_i);
        prev_b      = operand_b_model(issue_instr_i, rd_clobber_i, rs2_valid_i, rs2_i);
        prev_imm    = issue_instr_i.result;
        prev_pc     = issue_instr_i.pc;
        prev_fu     = issue_instr_i.fu;
        prev_op     = issue_instr_i.op;
        prev_tid    = issue_instr_i.trans_id;
        prev_strobe = decode_strobes(issue_instr_i, issue_instr_valid_i && ack_exp, flush_i);
        have_prev   = 1'b1;
        mult_pending_exp = prev_strobe[3];
        // commits of this cycle are seen from the next cycle on
        apply_commits(commit_i);
        acked = issue_instr_valid_i && ack_exp;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        issue_instr_t ins;
        logic         acked;
        int unsigned  tries;
        lfsr_q              = 16'd81;
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        issue_instr_i       = '0;
        issue_instr_valid_i = 1'b0;
        rs1_i               = '0;
        rs2_i               = '0;
        rs1_valid_i         = 1'b0;
        rs2_valid_i         = 1'b0;
        rd_clobber_i        = '0;
        flu_ready_i         = 1'b0;
        lsu_ready_i         = 1'b0;
        commit_i            = '0;
        have_prev           = 1'b0;
        mult_pending_exp    = 1'b0;
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            shadow_regs[r] = '0;
        end

        repeat (9) @(posedge clk_i);
        @(negedge clk_i);
        check_value(fu_data_o.fu, NONE, "unit in reset");
        check_value(fu_data_o.op, ADD, "operation in reset");
        check_value(fu_data_o.operand_a, '0, "operand a in reset");
        check_value(strobes, '0, "strobes in reset");
        @(posedge clk_i);
        rst_ni <= 1'b1;

        // load every register through the commit ports
        for (int i = 0; i < 16; i++) begin
            drive_cycle('0, 1'b0, 1'b1, i);
            check_cycle(acked);
        end

        for (int n = 0; n < NR_INSTRS; n++) begin
            ins = random_instr();
            // now and then a cycle with nothing offered
            if (rand_bits(3) == 0) begin
                drive_cycle(random_instr(), 1'b0, 1'b0, -1);
                check_cycle(acked);
            end
            tries = 0;
            acked = 1'b0;
            while (!acked) begin
                if (tries == MAX_WAIT) begin
                    $display("ERROR at %0t: instruction %0d was never acknowledged", $time, n);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "issue wait timed out");
                end
                drive_cycle(ins, 1'b1, tries >= 8, -1);
                check_cycle(acked);
                tries++;
            end
        end

        // one more cycle so the last strobe is checked
        drive_cycle(random_instr(), 1'b0, 1'b1, -1);
        check_cycle(acked);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
